// ==== design/sync_pkg.sv ====
package sync_pkg;

  // System time counts clock cycles, EtherCAT time counts nanoseconds.
  typedef logic [63:0] sys_time_t;
  typedef logic [63:0] ecat_time_t;
  typedef logic [17:0] period_cnt_t;

  // Signed two's complement, saturated at the range ends.
  typedef logic [18:0] time_err_t;

  // One sync lap is 500 us.
  localparam logic [31:0] EcatSyncBaseNs = 32'd500000;

  localparam logic [31:0] RegCtrl       = 32'h00;
  localparam logic [31:0] RegSyncTimeLo = 32'h04;
  localparam logic [31:0] RegSyncTimeHi = 32'h08;
  localparam logic [31:0] RegBaseCnt    = 32'h0C;
  localparam logic [31:0] RegStatus     = 32'h10;
  localparam logic [31:0] RegSysTimeLo  = 32'h14;
  localparam logic [31:0] RegSysTimeHi  = 32'h18;

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    ARMED,
    RUN
  } sync_state_t;

endpackage

// ==== design/sync_axil_regs.sv ====
module sync_axil_regs #(
  parameter int AXIL_ADDR_W = 5
) (
  input  logic                   CLK,
  input  logic                   arst_n,
  input  logic [AXIL_ADDR_W-1:0] awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [31:0]            wdata,
  input  logic [3:0]             wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output logic [1:0]             bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  logic [AXIL_ADDR_W-1:0] araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [31:0]            rdata,
  output logic [1:0]             rresp,
  output logic                   rvalid,
  input  logic                   rready,
  input  sync_pkg::sys_time_t    sys_time,
  input  logic                   pending,
  input  logic                   running,
  output logic                   update,
  output sync_pkg::ecat_time_t   ecat_sync_time,
  output sync_pkg::period_cnt_t  base_cnt
);
  import sync_pkg::*;

  logic                   aw_held;
  logic                   w_held;
  logic [AXIL_ADDR_W-1:0] aw_addr_q;
  logic [31:0]            w_data_q;
  logic [3:0]             w_strb_q;
  logic                   aw_hs;
  logic                   w_hs;
  logic                   ar_hs;
  logic                   wr_fire;
  logic [AXIL_ADDR_W-1:0] wr_addr;
  logic [31:0]            wr_data;
  logic [3:0]             wr_strb;
  logic [31:0]            rd_data;
  logic [31:0]            sys_time_hi_q;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_val;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Address and data are taken independently; no new write while a response waits.
  assign awready = ~aw_held & ~bvalid;
  assign wready  = ~w_held & ~bvalid;
  assign arready = ~rvalid;
  assign aw_hs   = awvalid & awready;
  assign w_hs    = wvalid & wready;
  assign ar_hs   = arvalid & arready;
  assign bresp   = 2'b00;
  assign rresp   = 2'b00;

  assign wr_fire = (aw_held | aw_hs) & (w_held | w_hs);
  assign wr_addr = aw_held ? aw_addr_q : awaddr;
  assign wr_data = w_held ? w_data_q : wdata;
  assign wr_strb = w_held ? w_strb_q : wstrb;

  always_ff @(posedge CLK) begin
    if (aw_hs) begin
      aw_addr_q <= awaddr;
    end
    if (w_hs) begin
      w_data_q <= wdata;
      w_strb_q <= wstrb;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      aw_held <= 1'b0;
      w_held  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      if (wr_fire) begin
        aw_held <= 1'b0;
        w_held  <= 1'b0;
        bvalid  <= 1'b1;
      end else begin
        if (aw_hs) begin
          aw_held <= 1'b1;
        end
        if (w_hs) begin
          w_held <= 1'b1;
        end
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      update         <= 1'b0;
      ecat_sync_time <= '0;
      base_cnt       <= '0;
    end else begin
      update <= 1'b0;
      if (wr_fire) begin
        case (32'(wr_addr))
          RegCtrl:       update <= wr_strb[0] & wr_data[0];
          RegSyncTimeLo: ecat_sync_time[31:0] <= merge_bytes(ecat_sync_time[31:0], wr_data,
                                                             wr_strb);
          RegSyncTimeHi: ecat_sync_time[63:32] <= merge_bytes(ecat_sync_time[63:32], wr_data,
                                                              wr_strb);
          RegBaseCnt:    base_cnt <= period_cnt_t'(merge_bytes(32'(base_cnt), wr_data, wr_strb));
          default:       ;
        endcase
      end
    end
  end

  always_comb begin
    case (32'(araddr))
      RegSyncTimeLo: rd_data = ecat_sync_time[31:0];
      RegSyncTimeHi: rd_data = ecat_sync_time[63:32];
      RegBaseCnt:    rd_data = 32'(base_cnt);
      RegStatus:     rd_data = {30'd0, running, pending};
      RegSysTimeLo:  rd_data = sys_time[31:0];
      RegSysTimeHi:  rd_data = sys_time_hi_q;
      default:       rd_data = '0;
    endcase
  end

  // Reading the low half freezes the high half for the next read.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      rvalid        <= 1'b0;
      rdata         <= '0;
      sys_time_hi_q <= '0;
    end else begin
      if (ar_hs) begin
        rvalid <= 1'b1;
        rdata  <= rd_data;
        if (32'(araddr) == RegSysTimeLo) begin
          sys_time_hi_q <= sys_time[63:32];
        end
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

endmodule

// ==== design/sync_ctrl.sv ====
module sync_ctrl (
  input  logic CLK,
  input  logic arst_n,
  input  logic ecat_sync,
  input  logic update,
  input  logic lap_done,
  output logic lap_start,
  output logic sync,
  output logic load,
  output logic pending,
  output logic running
);
  import sync_pkg::*;

  logic [2:0]  sync_sr;
  sync_state_t state;

  // Two stages for metastability, the third keeps the previous level.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      sync_sr <= '0;
    end else begin
      sync_sr <= {sync_sr[1:0], ecat_sync};
    end
  end

  assign sync = sync_sr[1] & ~sync_sr[2];

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state     <= IDLE;
      lap_start <= 1'b0;
    end else begin
      lap_start <= update;
      if (update) begin
        state <= CALC;
      end else begin
        case (state)
          // A done pulse next to a restart belongs to the old request.
          CALC: begin
            if (lap_done && !lap_start) begin
              state <= ARMED;
            end
          end
          ARMED: begin
            if (sync) begin
              state <= RUN;
            end
          end
          default: ;
        endcase
      end
    end
  end

  assign load    = sync & (state == ARMED) & ~update;
  assign pending = (state == CALC) | (state == ARMED);
  assign running = (state == RUN);

endmodule

// ==== design/sync_lap_calc.sv ====
module sync_lap_calc (
  input  logic                  CLK,
  input  logic                  arst_n,
  input  logic                  lap_start,
  input  sync_pkg::ecat_time_t  ecat_sync_time,
  input  sync_pkg::period_cnt_t base_cnt,
  output logic                  lap_done,
  output sync_pkg::sys_time_t   sync_time
);
  import sync_pkg::*;

  logic        busy;
  logic        mul_step;
  logic [5:0]  step;
  logic [63:0] quo;
  logic [31:0] rem;
  logic [32:0] trial;

  // Remainder stays below the base, so bit 32 is the borrow.
  assign trial = {rem, quo[63]} - {1'b0, EcatSyncBaseNs};

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      busy     <= 1'b0;
      mul_step <= 1'b0;
      step     <= '0;
      lap_done <= 1'b0;
    end else begin
      lap_done <= 1'b0;
      if (lap_start) begin
        busy     <= 1'b1;
        mul_step <= 1'b0;
        step     <= '0;
      end else if (busy) begin
        step <= step + 1'b1;
        if (step == 6'd63) begin
          busy     <= 1'b0;
          mul_step <= 1'b1;
        end
      end else if (mul_step) begin
        mul_step <= 1'b0;
        lap_done <= 1'b1;
      end
    end
  end

  // One quotient bit per cycle, shifted in from the right.
  always_ff @(posedge CLK) begin
    if (lap_start) begin
      quo <= ecat_sync_time;
      rem <= '0;
    end else if (busy) begin
      if (trial[32]) begin
        rem <= {rem[30:0], quo[63]};
        quo <= {quo[62:0], 1'b0};
      end else begin
        rem <= trial[31:0];
        quo <= {quo[62:0], 1'b1};
      end
    end
    if (mul_step) begin
      sync_time <= quo * base_cnt;
    end
  end

endmodule

// ==== design/sync_period_timer.sv ====
module sync_period_timer (
  input  logic                  CLK,
  input  logic                  arst_n,
  input  logic                  sync,
  input  logic                  load,
  input  sync_pkg::sys_time_t   sync_time,
  input  sync_pkg::period_cnt_t base_cnt,
  output sync_pkg::sys_time_t   next_sync_time
);
  import sync_pkg::*;

  period_cnt_t phase;
  period_cnt_t half_cnt;

  assign half_cnt = base_cnt >> 1;

  // The grid time steps forward half a period before the expected sync,
  // so each sync is measured against the closest grid point.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      phase          <= '0;
      next_sync_time <= '0;
    end else if (load) begin
      phase          <= half_cnt;
      next_sync_time <= sync_time;
    end else if (sync) begin
      phase <= half_cnt;
    end else if (phase == base_cnt - 1'b1) begin
      phase          <= '0;
      next_sync_time <= next_sync_time + base_cnt;
    end else begin
      phase <= phase + 1'b1;
    end
  end

endmodule

// ==== design/sys_time_slew.sv ====
module sys_time_slew (
  input  logic                CLK,
  input  logic                arst_n,
  input  logic                sync,
  input  logic                load,
  input  sync_pkg::sys_time_t sync_time,
  input  sync_pkg::sys_time_t next_sync_time,
  output sync_pkg::sys_time_t sys_time,
  output logic                skip_one_assert
);
  import sync_pkg::*;

  time_err_t          err;
  time_err_t          err_sat;
  logic               loaded;
  logic signed [63:0] diff;

  // Measured against the count reached right after the sync cycle.
  assign diff = $signed(next_sync_time - sys_time - 64'd1);

  always_comb begin
    if (diff > 64'sd262143) begin
      err_sat = 19'h3ffff;
    end else if (diff < -64'sd262144) begin
      err_sat = 19'h40000;
    end else begin
      err_sat = diff[18:0];
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      sys_time        <= '0;
      err             <= '0;
      loaded          <= 1'b0;
      skip_one_assert <= 1'b0;
    end else begin
      skip_one_assert <= 1'b0;
      if (load) begin
        sys_time <= sync_time;
        err      <= '0;
        loaded   <= 1'b1;
      end else if (sync && loaded) begin
        sys_time <= sys_time + 1'b1;
        err      <= err_sat;
      end else if (err == '0) begin
        sys_time <= sys_time + 1'b1;
      end else if (err[18]) begin
        // Ahead of the grid. Hold one cycle.
        err <= err + 1'b1;
      end else begin
        sys_time        <= sys_time + 2'd2;
        err             <= err - 1'b1;
        skip_one_assert <= 1'b1;
      end
    end
  end

endmodule

// ==== design/sync_top.sv ====
module sync_top #(
  parameter int AXIL_ADDR_W = 5
) (
  input  logic                   CLK,
  input  logic                   arst_n,
  input  logic                   ecat_sync,
  input  logic [AXIL_ADDR_W-1:0] awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [31:0]            wdata,
  input  logic [3:0]             wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output logic [1:0]             bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  logic [AXIL_ADDR_W-1:0] araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [31:0]            rdata,
  output logic [1:0]             rresp,
  output logic                   rvalid,
  input  logic                   rready,
  output sync_pkg::sys_time_t    sys_time,
  output logic                   sync,
  output logic                   skip_one_assert
);
  import sync_pkg::*;

  logic        update;
  ecat_time_t  ecat_sync_time;
  period_cnt_t base_cnt;
  logic        lap_start;
  logic        lap_done;
  sys_time_t   sync_time;
  sys_time_t   next_sync_time;
  logic        load;
  logic        pending;
  logic        running;

  // Internal nets carry the same names as the ports they join.
  sync_axil_regs #(
    .AXIL_ADDR_W(AXIL_ADDR_W)
  ) u_regs (.*);

  sync_ctrl u_ctrl (.*);

  sync_lap_calc u_lap_calc (.*);

  sync_period_timer u_timer (.*);

  sys_time_slew u_slew (.*);

endmodule

// ==== test/tb_sync_tasks.svh ====
`ifndef TB_SYNC_TASKS_SVH
`define TB_SYNC_TASKS_SVH

// Whole laps in the sync time, times the period.
function automatic sys_time_t ref_sync_time(input ecat_time_t ns, input period_cnt_t period);
  sys_time_t laps;
  laps = ns / 64'(EcatSyncBaseNs);
  return laps * 64'(period);
endfunction

task automatic wait_cycles(input int n);
  repeat (n) begin
    @(posedge CLK);
    #DriveDelay;
  end
endtask

// Ready is sampled after the drive point, so it holds for the coming edge.
task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
  logic aw_ok;
  logic w_ok;
  awaddr  = addr[AddrW-1:0];
  awvalid = 1'b1;
  wdata   = data;
  wstrb   = 4'hf;
  wvalid  = 1'b1;
  bready  = 1'b1;
  while (awvalid || wvalid) begin
    aw_ok = awvalid & awready;
    w_ok  = wvalid & wready;
    wait_cycles(1);
    if (aw_ok) begin
      awvalid = 1'b0;
    end
    if (w_ok) begin
      wvalid = 1'b0;
    end
  end
  while (!bvalid) begin
    wait_cycles(1);
  end
  if (bresp !== 2'b00) begin
    $display("ERROR %s: expected bresp 0, actual %0d", cur_test, bresp);
    errors++;
  end
  wait_cycles(1);
  bready = 1'b0;
endtask

task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
  logic ar_ok;
  araddr  = addr[AddrW-1:0];
  arvalid = 1'b1;
  rready  = 1'b1;
  while (arvalid) begin
    ar_ok = arready;
    wait_cycles(1);
    if (ar_ok) begin
      arvalid = 1'b0;
    end
  end
  while (!rvalid) begin
    wait_cycles(1);
  end
  data = rdata;
  if (rresp !== 2'b00) begin
    $display("ERROR %s: expected rresp 0, actual %0d", cur_test, rresp);
    errors++;
  end
  wait_cycles(1);
  rready = 1'b0;
endtask

// Gap is counted from the previous rising edge of SYNC0.
task automatic send_sync_pulse(input int gap);
  while (cycle_cnt < last_rise + gap) begin
    wait_cycles(1);
  end
  ecat_sync = 1'b1;
  last_rise = cycle_cnt;
  // Two capture stages, so sync is high only in the cycle that the third edge closes.
  for (int i = 1; i <= PulseWidth; i++) begin
    wait_cycles(1);
    if (sync !== (i == SyncStages)) begin
      $display("ERROR %s: expected sync %0b, actual %0b", cur_test, i == SyncStages, sync);
      errors++;
    end
  end
  ecat_sync = 1'b0;
endtask

`endif

// ==== test/tb_sync_top.sv ====
module tb_sync_top;
  import sync_pkg::*;

  localparam int AddrW        = 5;
  localparam int DriveDelay   = 10;
  localparam int ResetCycles  = 16;
  localparam int PulseWidth   = 4;
  localparam int SyncStages   = 2;
  localparam int LapCycles    = 70;
  localparam int SettleCycles = 24;
  localparam int MaxShift     = 20;
  localparam int NumPulses    = 11;
  localparam int AxiOps       = 16;
  localparam int AxiCycles    = 8;

  logic             CLK;
  logic             arst_n;
  logic             ecat_sync;
  logic [AddrW-1:0] awaddr;
  logic             awvalid;
  logic             awready;
  logic [31:0]      wdata;
  logic [3:0]       wstrb;
  logic             wvalid;
  logic             wready;
  logic [1:0]       bresp;
  logic             bvalid;
  logic             bready;
  logic [AddrW-1:0] araddr;
  logic             arvalid;
  logic             arready;
  logic [31:0]      rdata;
  logic [1:0]       rresp;
  logic             rvalid;
  logic             rready;
  sys_time_t        sys_time;
  logic             sync;
  logic             skip_one_assert;

  int          cycle_cnt;
  int          cycle_limit;
  int          last_rise;
  int          errors;
  int          errors_at_start;
  int          tests_run;
  int          tests_failed;
  string       cur_test;
  logic        sync_q;
  logic        load_pending;
  logic        tracking;
  int          since_sync;
  int          settle_checks;
  int          skip_cnt;
  sys_time_t   load_value;
  sys_time_t   grid;
  period_cnt_t period;
  ecat_time_t  sync_ns;
  sys_time_t   first_ref;
  logic [31:0] rd;
  int          shift;
  int          target;

  `include "tb_sync_tasks.svh"

  sync_top #(
    .AXIL_ADDR_W(AddrW)
  ) UUT (
    .CLK(CLK), .arst_n(arst_n), .ecat_sync(ecat_sync),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .sys_time(sys_time), .sync(sync), .skip_one_assert(skip_one_assert)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Done: errors found");
      $finish;
    end
  end

  // Grid point of the latest sync. Each pulse after the load adds one period.
  always @(negedge CLK) begin
    if (sync_q) begin
      since_sync = 0;
      if (load_pending) begin
        grid         = load_value;
        tracking     = 1'b1;
        load_pending = 1'b0;
        if (sys_time !== load_value) begin
          $display("ERROR %s: expected %h, actual %h", cur_test, load_value, sys_time);
          errors++;
        end
      end else begin
        grid = grid + 64'(period);
      end
    end else begin
      since_sync++;
    end
    if (tracking && since_sync == SettleCycles) begin
      if (sys_time !== grid + SettleCycles) begin
        $display("ERROR %s: expected %h, actual %h", cur_test, grid + SettleCycles, sys_time);
        errors++;
      end
      settle_checks++;
    end
    if (skip_one_assert) begin
      skip_cnt++;
    end
    sync_q = sync;
  end

  task automatic begin_test(input string name);
    cur_test        = name;
    errors_at_start = errors;
    skip_cnt        = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == errors_at_start) begin
      $display("PASS %s", cur_test);
    end else begin
      tests_failed++;
      $display("FAIL %s (%0d errors)", cur_test, errors - errors_at_start);
    end
  endtask

  task automatic wait_settled(input int count);
    while (settle_checks < count) begin
      wait_cycles(1);
    end
  endtask

  task automatic check_skips(input int expected);
    if (skip_cnt != expected) begin
      $display("ERROR %s: expected %0d, actual %0d", cur_test, expected, skip_cnt);
      errors++;
    end
  endtask

  initial begin
    arst_n        = 1'b0;
    ecat_sync     = 1'b0;
    awaddr        = '0;
    awvalid       = 1'b0;
    wdata         = '0;
    wstrb         = '0;
    wvalid        = 1'b0;
    bready        = 1'b0;
    araddr        = '0;
    arvalid       = 1'b0;
    rready        = 1'b0;
    cycle_cnt     = 0;
    last_rise     = 0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    sync_q        = 1'b0;
    load_pending  = 1'b0;
    tracking      = 1'b0;
    since_sync    = 0;
    settle_checks = 0;
    skip_cnt      = 0;
    // The first draw also seeds the generator.
    period        = period_cnt_t'(300 + ($urandom(32'h7848) % 200));
    sync_ns       = {$urandom, $urandom};
    cycle_limit   = ResetCycles + NumPulses * (int'(period) + SettleCycles + MaxShift)
                    + 2 * LapCycles + AxiOps * AxiCycles + 200;
    repeat (ResetCycles) @(posedge CLK);
    #DriveDelay;
    arst_n = 1'b1;
    wait_cycles(2);

    begin_test("register_access");
    write_reg(RegSyncTimeLo, sync_ns[31:0]);
    write_reg(RegSyncTimeHi, sync_ns[63:32]);
    write_reg(RegBaseCnt, 32'(period));
    read_reg(RegSyncTimeLo, rd);
    if (rd !== sync_ns[31:0]) begin
      $display("ERROR %s: expected %h, actual %h", cur_test, sync_ns[31:0], rd);
      errors++;
    end
    read_reg(RegSyncTimeHi, rd);
    if (rd !== sync_ns[63:32]) begin
      $display("ERROR %s: expected %h, actual %h", cur_test, sync_ns[63:32], rd);
      errors++;
    end
    read_reg(RegBaseCnt, rd);
    if (rd !== 32'(period)) begin
      $display("ERROR %s: expected %h, actual %h", cur_test, 32'(period), rd);
      errors++;
    end
    write_reg(RegCtrl, 32'h1);
    read_reg(RegStatus, rd);
    if (rd !== 32'h1) begin
      $display("ERROR %s: expected %h, actual %h", cur_test, 32'h1, rd);
      errors++;
    end
    end_test();

    begin_test("load");
    wait_cycles(LapCycles);
    first_ref    = ref_sync_time(sync_ns, period);
    load_value   = first_ref;
    load_pending = 1'b1;
    target       = settle_checks + 1;
    send_sync_pulse(0);
    while (load_pending) begin
      wait_cycles(1);
    end
    read_reg(RegStatus, rd);
    if (rd !== 32'h2) begin
      $display("ERROR %s: expected %h, actual %h", cur_test, 32'h2, rd);
      errors++;
    end
    wait_settled(target);
    end_test();

    begin_test("free_running");
    target = settle_checks + 4;
    repeat (4) send_sync_pulse(period);
    wait_settled(target);
    check_skips(0);
    end_test();

    begin_test("late_sync");
    shift  = 1 + ($urandom % MaxShift);
    target = settle_checks + 2;
    send_sync_pulse(period + shift);
    send_sync_pulse(period);
    wait_settled(target);
    check_skips(0);
    end_test();

    begin_test("early_sync");
    shift  = 1 + ($urandom % MaxShift);
    target = settle_checks + 2;
    send_sync_pulse(period - shift);
    send_sync_pulse(period);
    wait_settled(target);
    check_skips(shift);
    end_test();

    begin_test("reload");
    do begin
      sync_ns = {$urandom, $urandom};
    end while (ref_sync_time(sync_ns, period) == first_ref);
    write_reg(RegSyncTimeLo, sync_ns[31:0]);
    write_reg(RegSyncTimeHi, sync_ns[63:32]);
    write_reg(RegCtrl, 32'h1);
    wait_cycles(LapCycles);
    load_value   = ref_sync_time(sync_ns, period);
    load_pending = 1'b1;
    target       = settle_checks + 2;
    send_sync_pulse(period);
    send_sync_pulse(period);
    wait_settled(target);
    end_test();

    $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+test
design/sync_pkg.sv
design/sync_axil_regs.sv
design/sync_ctrl.sv
design/sync_lap_calc.sv
design/sync_period_timer.sv
design/sys_time_slew.sv
design/sync_top.sv
test/tb_sync_top.sv

// ==== Bender.yml ====
package:
  name: ecat_sync_time

sources:
  - files:
      - design/sync_pkg.sv
      - design/sync_axil_regs.sv
      - design/sync_ctrl.sv
      - design/sync_lap_calc.sv
      - design/sync_period_timer.sv
      - design/sys_time_slew.sv
      - design/sync_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_sync_top.sv
